// File: src.f
+incdir+logic
logic/game_pkg.sv
logic/cen_gen.sv
logic/vtimer.sv
logic/cfg_regs.sv
logic/char_fetch.sv
logic/rom_slots.sv
logic/game_core.sv
dv/game_props.sv
dv/game_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the game core testbench with Verilator and run it
# The run passes only when the pass message shows up in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
    --top-module game_tb -f src.f -o game_sim &&
    ./obj_dir/game_sim 2>&1 | tee /dev/stderr |
    grep -F "Simulation completed successfully" > /dev/null &&
    echo "PASS" || {
    echo "FAIL"
    exit 1
}

// File: dv/game_input.txt
# W addr data: register write, R addr expected: main ROM read
# F n: check n frames, pending reads run during the first of them
F 1
W 1 01
F 1
W 0 02
R 000100 00FF
R 001234 34CB
F 2
W 0 03
R 0ABCDE DE21
R 000055 55AA
R 3FFFF0 F00F
F 1
W 1 00
R 200013 13EC
R 000081 817E
F 1
W 3 FF
R 12345A 5AA5
F 1
W 0 00
F 1

// File: dv/game_tb.sv
// Game core testbench
// Plays the SDRAM bank and the main CPU from a command file, checks
// ROM reads, the register handshake, raster timing and every pixel
`timescale 1ns/1ps
`include "game_settings.svh"

module game_tb import game_pkg::*; ();

    localparam int LINE_CYC  = `H_TOTAL * 4;
    localparam int FRAME_CYC = `V_TOTAL * LINE_CYC;

    logic      clk = 1'b0;
    logic      reset;
    logic      pxl2_cen, pxl_cen;
    color_t    red, green, blue;
    logic      HS, VS, LHBL_dly, LVBL_dly, vint;
    logic      main_cs, main_ok;
    rom_addr_t main_addr;
    rom_word_t main_data;
    logic      cfg_req, cfg_ack;
    cfg_wr_t   cfg_wr;
    rom_addr_t ba_addr;
    logic      ba_rd, ba_ack, ba_dok;
    rom_word_t data_read;

    logic [31:0] lfsr = 32'hada5;
    int          cyc = 0;
    int          rst_cyc = 0;
    int          limit;
    bit          limit_set = 1'b0;
    bit          passed = 1'b0;
    bit          fail_shown = 1'b0;
    bit          in_active = 1'b0;
    // Expected register contents
    logic        m_flip, m_video_en, m_pal;
    logic [7:0]  cmd_q[$];
    logic [31:0] arg_a[$];
    logic [31:0] arg_b[$];
    rom_addr_t   rd_addr_q[$];
    rom_word_t   rd_exp_q[$];

    always #4 clk = ~clk;
    always @(posedge clk) cyc <= cyc + 1;

    // Clock edges seen since reset was released
    always @(posedge clk) begin
        if (!reset) begin
            rst_cyc <= rst_cyc + 1;
        end
    end

    game_core u_game_core (.*);

    bind game_core game_props u_props (
        .clk(clk), .reset(reset), .ba_rd(ba_rd), .ba_ack(ba_ack), .main_ok(main_ok),
        .char_ok(char_ok), .cfg_req(cfg_req), .cfg_ack(cfg_ack), .HS(HS)
    );

    task automatic stop_run();
        fail_shown = 1'b1;
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input rom_word_t got, input rom_word_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
            stop_run();
        end
    endtask

    task automatic check_color(input string name, input color_t got, input color_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t %s expected %b got %b", $time, name, exp, got);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERR %0t %s expected %0d got %0d", $time, name, exp, got);
            stop_run();
        end
    endtask

    // pxl2_cen on every second edge out of reset, pxl_cen on every fourth
    always @(negedge clk) begin
        check_bit("pxl2_cen", pxl2_cen, rst_cyc > 0 && rst_cyc % 2 == 0);
        check_bit("pxl_cen", pxl_cen, rst_cyc > 0 && rst_cyc % 4 == 0);
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? (s >> 1) ^ 32'hD000_0001 : s >> 1;
    endfunction

    // Two LFSR bits give a wait of 1 to 3 cycles
    task automatic draw_wait(output int d);
        logic [1:0] b;
        for (int i = 0; i < 2; i++) begin
            b[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
        d = b % 3 + 1;
    endtask

    function automatic rom_word_t sdram_word(input rom_addr_t a);
        return {a[7:0], ~a[7:0]};
    endfunction

    // Flip shows the line mirrored, so look up the mirrored position
    function automatic pix_idx_t pixel_index(input int x, input int y, input logic flip);
        int        xs;
        rom_word_t w;
        xs = flip ? `H_ACTIVE - 1 - x : x;
        w  = sdram_word(`CHAR_BASE + rom_addr_t'(y * 16 + xs / `TILE_W));
        return w[15 - 4 * (xs % `TILE_W) -: 4];
    endfunction

    task automatic after_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic next_pixel();
        do @(negedge clk); while (!pxl_cen);
    endtask

    task automatic wait_rise(input bit use_vs);
        do @(negedge clk); while (use_vs ? VS : HS);
        do @(negedge clk); while (!(use_vs ? VS : HS));
    endtask

    // SDRAM bank with one access in flight and random ack and data delays
    initial begin : sdram_model
        int        cnt;
        int        phase;
        rom_addr_t a;
        ba_ack    = 1'b0;
        ba_dok    = 1'b0;
        data_read = '0;
        phase     = 0;
        cnt       = 0;
        forever begin
            after_edge();
            ba_ack = 1'b0;
            ba_dok = 1'b0;
            if (phase == 0 && ba_rd) begin
                a = ba_addr;
                draw_wait(cnt);
                phase = 1;
            end
            if (phase == 1) begin
                if (cnt == 1) begin
                    ba_ack = 1'b1;
                    draw_wait(cnt);
                    phase = 2;
                end else begin
                    cnt--;
                end
            end else if (phase == 2) begin
                if (cnt == 1) begin
                    ba_dok    = 1'b1;
                    data_read = sdram_word(a);
                    phase     = 0;
                end else begin
                    cnt--;
                end
            end
        end
    end

    task automatic main_read(input rom_addr_t a, input rom_word_t exp);
        int waited;
        after_edge();
        main_addr = a;
        main_cs   = 1'b1;
        waited    = 0;
        do begin
            after_edge();
            waited++;
            if (waited > 100) begin
                $display("Main ROM read of address %h never got main_ok", a);
                stop_run();
            end
        end while (!main_ok);
        check_word("main_data", main_data, exp);
        after_edge();
        main_cs = 1'b0;
    endtask

    task automatic run_reads();
        while (rd_addr_q.size() > 0) begin
            main_read(rd_addr_q.pop_front(), rd_exp_q.pop_front());
        end
    endtask

    task automatic reg_write(input logic [1:0] a, input logic [7:0] d);
        after_edge();
        check_bit("cfg_ack", cfg_ack, 1'b0);
        cfg_wr.addr = a;
        cfg_wr.data = d;
        cfg_req     = 1'b1;
        after_edge();
        check_bit("cfg_ack", cfg_ack, 1'b1);
        cfg_req = 1'b0;
        after_edge();
        check_bit("cfg_ack", cfg_ack, 1'b0);
        if (a == 2'd0) begin
            m_flip     = d[0];
            m_video_en = d[1];
        end else if (a == 2'd1) begin
            m_pal = d[0];
        end
    endtask

    task automatic check_pixel(input int x, input int y, input logic active);
        pix_idx_t idx;
        color_t   er;
        color_t   eg;
        color_t   eb;
        er = '0;
        eg = '0;
        eb = '0;
        if (active && m_video_en) begin
            idx = pixel_index(x, y, m_flip);
            er  = {m_pal, idx};
            eg  = {idx, m_pal};
            eb  = {1'b0, idx};
        end
        check_color("red", red, er);
        check_color("green", green, eg);
        check_color("blue", blue, eb);
    endtask

    // Frames start at the rise of LVBL_dly, columns count pxl_cen in LHBL_dly
    task automatic check_frames(input int n);
        int x;
        int y;
        do next_pixel(); while (!vint);
        // vint lasts one pixel and leads the delayed blanking by two
        next_pixel();
        check_bit("vint", vint, 1'b0);
        check_bit("LVBL_dly", LVBL_dly, 1'b1);
        next_pixel();
        check_bit("LVBL_dly", LVBL_dly, 1'b0);
        for (int f = 0; f < n; f++) begin
            do next_pixel(); while (LVBL_dly);
            do next_pixel(); while (!LVBL_dly);
            in_active = 1'b1;
            x = 0;
            y = 0;
            while (y < `V_ACTIVE) begin
                if (!LVBL_dly) begin
                    $display("Vertical blanking began after only %0d lines", y);
                    stop_run();
                end
                check_pixel(x, y, LHBL_dly);
                if (LHBL_dly) begin
                    x++;
                end else if (x != 0) begin
                    check_count("pixels per line", x, `H_ACTIVE);
                    x = 0;
                    y++;
                end
                next_pixel();
            end
        end
        in_active = 1'b0;
    endtask

    initial begin
        int          fd;
        int          code;
        int          frames;
        int          f_cmds;
        int          t0;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [8*80-1:0] skip;
        reset      = 1'b1;
        main_cs    = 1'b0;
        main_addr  = '0;
        cfg_req    = 1'b0;
        cfg_wr     = '0;
        m_flip     = 1'b0;
        m_video_en = 1'b0;
        m_pal      = 1'b0;
        frames     = 0;
        f_cmds     = 0;
        fd = $fopen("dv/game_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the command file dv/game_input.txt");
            stop_run();
        end
        while ($fscanf(fd, " %c", kind) == 1) begin
            if (kind == "#") begin
                code = $fgets(skip, fd);
            end else begin
                b = '0;
                if (kind == "F") begin
                    code = $fscanf(fd, "%d", a);
                    if (code != 1) begin
                        $display("Frame command in the command file has no count");
                        stop_run();
                    end
                    frames += a;
                    f_cmds++;
                end else begin
                    code = $fscanf(fd, "%h %h", a, b);
                    if (code != 2) begin
                        $display("Command %c in the command file lacks an argument", kind);
                        stop_run();
                    end
                end
                cmd_q.push_back(kind);
                arg_a.push_back(a);
                arg_b.push_back(b);
            end
        end
        $fclose(fd);
        // Lead-in frames for each frame check and the sync measurement
        limit = frames * FRAME_CYC + 200 * cmd_q.size() + (f_cmds + 6) * FRAME_CYC;
        limit_set = 1'b1;

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        after_edge();
        check_color("red", red, '0);
        check_color("green", green, '0);
        check_color("blue", blue, '0);
        check_bit("cfg_ack", cfg_ack, 1'b0);
        wait_rise(1'b0);
        t0 = cyc;
        wait_rise(1'b0);
        check_count("HS period", cyc - t0, LINE_CYC);
        wait_rise(1'b1);
        t0 = cyc;
        wait_rise(1'b1);
        check_count("VS period", cyc - t0, FRAME_CYC);

        foreach (cmd_q[i]) begin
            a = arg_a[i];
            b = arg_b[i];
            case (cmd_q[i])
                "W": reg_write(a[1:0], b[7:0]);
                "R": begin
                    rd_addr_q.push_back(rom_addr_t'(a));
                    rd_exp_q.push_back(rom_word_t'(b));
                end
                "F": begin
                    // Pending main ROM reads compete with the character fetches
                    fork
                        check_frames(a);
                        begin
                            wait (in_active);
                            run_reads();
                        end
                    join
                end
                default: begin
                    $display("Unknown command %c in the command file", cmd_q[i]);
                    stop_run();
                end
            endcase
        end
        run_reads();
        passed = 1'b1;
        $display("Simulation completed successfully");
        $finish;
    end

    initial begin : watchdog
        wait (limit_set);
        repeat (limit) @(posedge clk);
        $display("Timeout, the tests did not finish within %0d cycles", limit);
        stop_run();
    end

    final begin
        if (!passed && !fail_shown) begin
            $display("Simulation failed");
        end
    end

endmodule

// File: dv/game_props.sv
// Game core bus checks
// Concurrent assertions on the SDRAM request, the ROM ok pulses,
// the register handshake and the horizontal sync width
`timescale 1ns/1ps
`include "game_settings.svh"

module game_props (
    input logic clk,
    input logic reset,
    input logic ba_rd,
    input logic ba_ack,
    input logic main_ok,
    input logic char_ok,
    input logic cfg_req,
    input logic cfg_ack,
    input logic HS
);

    // Bank request held until the bank takes it
    assert property (@(posedge clk) disable iff (reset) ba_rd && !ba_ack |=> ba_rd)
        else $error("ba_rd dropped before ba_ack");

    assert property (@(posedge clk) disable iff (reset) main_ok |=> !main_ok)
        else $error("main_ok longer than one cycle");

    assert property (@(posedge clk) disable iff (reset) char_ok |=> !char_ok)
        else $error("char_ok longer than one cycle");

    assert property (@(posedge clk) disable iff (reset) $rose(cfg_ack) |-> $past(cfg_req))
        else $error("cfg_ack rose without cfg_req");

    // Sync pulse is HS_LEN pixels of four clocks each
    assert property (@(posedge clk) disable iff (reset)
        $fell(HS) |-> $past(HS, `HS_LEN * 4) && !$past(HS, `HS_LEN * 4 + 1))
        else $error("HS pulse width wrong");

endmodule

// File: logic/game_core.sv
// Game core top level
// Pixel enables, video timer, control registers, the character layer
// and the SDRAM slot arbiter shared with main CPU ROM reads
`timescale 1ns/1ps

module game_core import game_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    output logic      pxl2_cen,
    output logic      pxl_cen,
    output color_t    red,
    output color_t    green,
    output color_t    blue,
    output logic      HS,
    output logic      VS,
    output logic      LHBL_dly,
    output logic      LVBL_dly,
    output logic      vint,
    // Main CPU ROM
    input  logic      main_cs,
    input  rom_addr_t main_addr,
    output rom_word_t main_data,
    output logic      main_ok,
    // Main CPU register port
    input  logic      cfg_req,
    input  cfg_wr_t   cfg_wr,
    output logic      cfg_ack,
    // SDRAM bank
    output rom_addr_t ba_addr,
    output logic      ba_rd,
    input  logic      ba_ack,
    input  logic      ba_dok,
    input  rom_word_t data_read
);

    vpos_t     vpos;
    cfg_t      cfg;
    rgb_t      rgb;
    logic      char_cs;
    logic      char_ok;
    rom_addr_t char_addr;
    rom_word_t char_data;

    assign red   = rgb.red;
    assign green = rgb.green;
    assign blue  = rgb.blue;

    cen_gen u_cen (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .pxl2_cen ( pxl2_cen ),
        .pxl_cen  ( pxl_cen  )
    );

    vtimer u_vtimer (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .pxl_cen ( pxl_cen ),
        .vpos    ( vpos    ),
        .HS      ( HS      ),
        .VS      ( VS      ),
        .vint    ( vint    )
    );

    cfg_regs u_cfg (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .cfg_req ( cfg_req ),
        .cfg_wr  ( cfg_wr  ),
        .cfg_ack ( cfg_ack ),
        .cfg     ( cfg     )
    );

    char_fetch u_char (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .pxl_cen   ( pxl_cen   ),
        .vpos      ( vpos      ),
        .cfg       ( cfg       ),
        .char_cs   ( char_cs   ),
        .char_addr ( char_addr ),
        .char_data ( char_data ),
        .char_ok   ( char_ok   ),
        .rgb       ( rgb       ),
        .LHBL_dly  ( LHBL_dly  ),
        .LVBL_dly  ( LVBL_dly  )
    );

    rom_slots u_slots (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .char_cs   ( char_cs   ),
        .char_addr ( char_addr ),
        .char_data ( char_data ),
        .char_ok   ( char_ok   ),
        .main_cs   ( main_cs   ),
        .main_addr ( main_addr ),
        .main_data ( main_data ),
        .main_ok   ( main_ok   ),
        .ba_addr   ( ba_addr   ),
        .ba_rd     ( ba_rd     ),
        .ba_ack    ( ba_ack    ),
        .ba_dok    ( ba_dok    ),
        .data_read ( data_read )
    );

endmodule

// File: logic/rom_slots.sv
// SDRAM bank slots
// Arbitrates the character layer and the main CPU ROM onto one bank
// Character requests win ties, one access is in flight at a time and
// the data goes back registered with a single cycle ok
`timescale 1ns/1ps

module rom_slots import game_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      char_cs,
    input  rom_addr_t char_addr,
    output rom_word_t char_data,
    output logic      char_ok,
    input  logic      main_cs,
    input  rom_addr_t main_addr,
    output rom_word_t main_data,
    output logic      main_ok,
    output rom_addr_t ba_addr,
    output logic      ba_rd,
    input  logic      ba_ack,
    input  logic      ba_dok,
    input  rom_word_t data_read
);

    slot_state_t state;
    logic        owner_char;
    logic        char_done;
    logic        main_done;
    logic        finish;
    logic        can_grant;
    logic        char_want;
    logic        main_want;

    assign finish    = state == WAIT_DOK && ba_dok;
    // A new grant may follow straight on from a finishing access
    assign can_grant = state == IDLE || finish;
    assign char_want = char_cs && !char_done && !(finish && owner_char);
    assign main_want = main_cs && !main_done && !(finish && !owner_char);
    assign ba_rd     = state == WAIT_ACK;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            owner_char <= 1'b0;
        end else if (can_grant && (char_want || main_want)) begin
            state      <= WAIT_ACK;
            owner_char <= char_want;
        end else begin
            case (state)
                WAIT_ACK: if (ba_ack) state <= WAIT_DOK;
                WAIT_DOK: if (ba_dok) state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (can_grant && (char_want || main_want)) begin
            ba_addr <= char_want ? char_addr : main_addr;
        end
    end

    // Served flags hold off a requester until its cs has dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            char_done <= 1'b0;
            main_done <= 1'b0;
            char_ok   <= 1'b0;
            main_ok   <= 1'b0;
        end else begin
            char_done <= (finish && owner_char) || (char_done && char_cs);
            main_done <= (finish && !owner_char) || (main_done && main_cs);
            char_ok   <= finish && owner_char;
            main_ok   <= finish && !owner_char;
        end
    end

    always_ff @(posedge clk) begin
        if (finish) begin
            if (owner_char) begin
                char_data <= data_read;
            end else begin
                main_data <= data_read;
            end
        end
    end

endmodule

// File: logic/char_fetch.sv
// Character layer
// Fetches one ROM word per tile a tile ahead of the beam, keeps one
// word in the shifter and one in the prefetch buffer, and turns the
// pixel index into colour. Output and blanking share a two pixel delay
`timescale 1ns/1ps
`include "game_settings.svh"

module char_fetch import game_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      pxl_cen,
    input  vpos_t     vpos,
    input  cfg_t      cfg,
    output logic      char_cs,
    output rom_addr_t char_addr,
    input  rom_word_t char_data,
    input  logic      char_ok,
    output rgb_t      rgb,
    output logic      LHBL_dly,
    output logic      LVBL_dly
);

    logic [3:0] nxt_tile;
    logic [3:0] col;
    vcnt_t      fline;
    logic       tile_start;
    logic       fetch_now;
    logic       req_flip;
    rom_word_t  in_word;
    rom_word_t  pre_buf;
    rom_word_t  shift;
    rom_word_t  cur;
    pix_idx_t   pix1;
    logic       lhbl1;
    logic       lvbl1;
    logic       blank;

    // Tile after the current one, wraps to tile 0 of the next line
    assign nxt_tile   = vpos.hcount[5:2] + 4'd1;
    assign tile_start = vpos.hcount[1:0] == 2'd0;

    always_comb begin
        fline = vpos.vcount;
        if (nxt_tile == 4'd0) begin
            fline = (vpos.vcount == vcnt_t'(`V_TOTAL - 1)) ? '0 : vpos.vcount + 1'd1;
        end
    end

    assign fetch_now = pxl_cen && tile_start &&
                       nxt_tile < 4'(`H_ACTIVE / `TILE_W) &&
                       fline < vcnt_t'(`V_ACTIVE);
    // Mirrored column under flip
    assign col = cfg.flip ? 4'(`H_ACTIVE / `TILE_W - 1) - nxt_tile : nxt_tile;

    always_ff @(posedge clk) begin
        if (reset) begin
            char_cs <= 1'b0;
        end else if (fetch_now) begin
            char_cs <= 1'b1;
        end else if (char_ok) begin
            char_cs <= 1'b0;
        end
    end

    // Nibbles are reversed on arrival so the shifter always reads 15:12
    assign in_word = req_flip ?
                     {char_data[3:0], char_data[7:4], char_data[11:8], char_data[15:12]} :
                     char_data;
    assign cur     = tile_start ? pre_buf : shift;

    always_ff @(posedge clk) begin
        if (fetch_now) begin
            char_addr <= `CHAR_BASE + rom_addr_t'({fline[3:0], col});
            req_flip  <= cfg.flip;
        end
        if (char_ok) pre_buf <= in_word;
        if (pxl_cen) begin
            shift <= {cur[11:0], 4'd0};
            pix1  <= cur[15:12];
        end
    end

    assign blank = !lhbl1 || !lvbl1 || !cfg.video_en;

    always_ff @(posedge clk) begin
        if (reset) begin
            lhbl1    <= 1'b0;
            lvbl1    <= 1'b0;
            LHBL_dly <= 1'b0;
            LVBL_dly <= 1'b0;
            rgb      <= '0;
        end else if (pxl_cen) begin
            lhbl1    <= !vpos.hb;
            lvbl1    <= !vpos.vb;
            LHBL_dly <= lhbl1;
            LVBL_dly <= lvbl1;
            if (blank) begin
                rgb <= '0;
            end else begin
                rgb.red   <= {cfg.pal_bank, pix1};
                rgb.green <= {pix1, cfg.pal_bank};
                rgb.blue  <= {1'b0, pix1};
            end
        end
    end

endmodule

// File: logic/cfg_regs.sv
// Video control registers
// Written by the main CPU over a four-phase req/ack port
// Register 0 holds flip and video enable, register 1 the palette bank
`timescale 1ns/1ps

module cfg_regs import game_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    cfg_req,
    input  cfg_wr_t cfg_wr,
    output logic    cfg_ack,
    output cfg_t    cfg
);

    hs_state_t state;
    cfg_wr_t   wr_q;
    logic      wr_pend;

    assign cfg_ack = state == HS_ACK;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= HS_IDLE;
            wr_pend <= 1'b0;
            cfg     <= '0;
        end else begin
            wr_pend <= 1'b0;
            case (state)
                HS_IDLE: begin
                    if (cfg_req) begin
                        state   <= HS_ACK;
                        wr_pend <= 1'b1;
                    end
                end
                HS_ACK: begin
                    if (!cfg_req) state <= HS_IDLE;
                end
                default: state <= HS_IDLE;
            endcase
            // One update per request, a cycle after ack goes up
            if (wr_pend) begin
                case (wr_q.addr)
                    2'd0: begin
                        cfg.flip     <= wr_q.data[0];
                        cfg.video_en <= wr_q.data[1];
                    end
                    2'd1: cfg.pal_bank <= wr_q.data[0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == HS_IDLE && cfg_req) wr_q <= cfg_wr;
    end

endmodule

// File: logic/vtimer.sv
// Video timer
// Horizontal and vertical raster counters stepped by pxl_cen, with
// blanking, sync decode and the vertical interrupt at the start of
// vertical blanking
`timescale 1ns/1ps
`include "game_settings.svh"

module vtimer import game_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  pxl_cen,
    output vpos_t vpos,
    output logic  HS,
    output logic  VS,
    output logic  vint
);

    hcnt_t hcount;
    vcnt_t vcount;
    logic  h_last;
    logic  v_last;

    assign h_last = hcount == hcnt_t'(`H_TOTAL - 1);
    assign v_last = vcount == vcnt_t'(`V_TOTAL - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
            vint   <= 1'b0;
        end else if (pxl_cen) begin
            hcount <= h_last ? '0 : hcount + 1'd1;
            vint   <= 1'b0;
            if (h_last) begin
                vcount <= v_last ? '0 : vcount + 1'd1;
                // Entering the first blank line
                vint   <= vcount == vcnt_t'(`V_ACTIVE - 1);
            end
        end
    end

    assign vpos = '{
        hcount: hcount,
        vcount: vcount,
        hb:     hcount >= hcnt_t'(`H_ACTIVE),
        vb:     vcount >= vcnt_t'(`V_ACTIVE)
    };

    assign HS = hcount >= hcnt_t'(`HS_START) &&
                hcount <  hcnt_t'(`HS_START + `HS_LEN);
    assign VS = vcount >= vcnt_t'(`VS_START) &&
                vcount <  vcnt_t'(`VS_START + `VS_LEN);

endmodule

// File: logic/cen_gen.sv
// Pixel clock enables
// One free running 2-bit count gives pxl2_cen on every second clk
// and pxl_cen on every fourth, both phase aligned
`timescale 1ns/1ps

module cen_gen (
    input  logic clk,
    input  logic reset,
    output logic pxl2_cen,
    output logic pxl_cen
);

    logic [1:0] cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt      <= 2'd0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            cnt      <= cnt + 2'd1;
            // pxl_cen lands on every other pxl2_cen
            pxl2_cen <= cnt[0];
            pxl_cen  <= &cnt;
        end
    end

endmodule

// File: logic/game_pkg.sv
// Game core types
// ROM bus words, colour and raster types, video control structs and
// the state encodings of the SDRAM slot and the register handshake
`include "game_settings.svh"

package game_pkg;

    typedef logic [`ADDR_W-1:0] rom_addr_t;
    typedef logic [`DATA_W-1:0] rom_word_t;
    typedef logic [3:0]         pix_idx_t;
    typedef logic [4:0]         color_t;
    typedef logic [5:0]         hcnt_t;
    typedef logic [4:0]         vcnt_t;

    typedef struct packed {
        color_t red;
        color_t green;
        color_t blue;
    } rgb_t;

    // Beam position with blanking
    typedef struct packed {
        hcnt_t hcount;
        vcnt_t vcount;
        logic  hb;
        logic  vb;
    } vpos_t;

    typedef struct packed {
        logic flip;
        logic video_en;
        logic pal_bank;
    } cfg_t;

    typedef struct packed {
        logic [1:0] addr;
        logic [7:0] data;
    } cfg_wr_t;

    typedef enum logic [1:0] {IDLE, WAIT_ACK, WAIT_DOK} slot_state_t;
    typedef enum logic {HS_IDLE, HS_ACK} hs_state_t;

endpackage

// File: logic/game_settings.svh
// Game core settings
// Raster geometry, character ROM placement and SDRAM bus widths
`ifndef GAME_SETTINGS_SVH
`define GAME_SETTINGS_SVH

// Horizontal timing in pixels
`define H_TOTAL   64
`define H_ACTIVE  48
`define HS_START  52
`define HS_LEN    4

// Vertical timing in lines
`define V_TOTAL   20
`define V_ACTIVE  16
`define VS_START  17
`define VS_LEN    1

// Character layer, pixels per ROM word and word address of the region
`define TILE_W    4
`define CHAR_BASE 22'h200000

`define ADDR_W    22
`define DATA_W    16
`endif
